// File: hdl/dct_types_pkg.sv
// DCT types
// Widths and numeric types shared by the 8x8 DCT datapath, plus the
// state encoding of the input block sequencer

`default_nettype none

package dct_types_pkg;

	// Side length of the transform block
	localparam int BLOCK_N = 8;

	// Unsigned input sample of one image channel
	typedef logic [7:0] pixel_t;

	// First-pass (row) result, signed
	typedef logic signed [10:0] row_coef_t;

	// Final output coefficient, signed
	typedef logic signed [10:0] coef_t;

	// Wide accumulator for both passes
	typedef logic signed [31:0] acc_t;

	// Row or column position within the block
	typedef logic [2:0] idx_t;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_STREAM
	} seq_state_t;

endpackage

`default_nettype wire

// File: hdl/dct_coeff_pkg.sv
// DCT coefficients
// Scaled cosine basis T[u][c] with a 14-bit fraction, and the rounding
// rule applied after each pass

`default_nettype none

package dct_coeff_pkg;

	localparam int COEF_FRAC = 14;

	// u = 0 entry, sqrt(1/8) scaled
	localparam logic signed [15:0] COEF_DC = 16'sd5793;

	// T[u][c] = 0.5 * cos((2c+1) u pi / 16) * 2^14 for u > 0
	function automatic logic signed [15:0] dct_coeff(input dct_types_pkg::idx_t u,
		input dct_types_pkg::idx_t c);
		logic [6:0] k;
		logic [4:0] m;
		logic neg;
		logic signed [15:0] mag;
		k = (7'(c) * 7'd2 + 7'd1) * 7'(u);
		// Cosine has period 32 in units of pi/16
		m = k[4:0];
		if (m > 5'd16)
			m = 5'(6'd32 - 6'(m));
		// Second quadrant mirrors the first with a sign change
		neg = (m > 5'd8);
		if (neg)
			m = 5'd16 - m;
		case (m)
			5'd0: mag = 16'sd8192;
			5'd1: mag = 16'sd8035;
			5'd2: mag = 16'sd7568;
			5'd3: mag = 16'sd6811;
			5'd4: mag = 16'sd5793;
			5'd5: mag = 16'sd4551;
			5'd6: mag = 16'sd3135;
			5'd7: mag = 16'sd1598;
			default: mag = 16'sd0;
		endcase
		if (u == 3'd0)
			return COEF_DC;
		return neg ? -mag : mag;
	endfunction

	// Keep the bits above the fraction, round up on the top fraction bit
	function automatic logic signed [10:0] round_frac(input dct_types_pkg::acc_t a);
		logic signed [10:0] whole;
		whole = a[COEF_FRAC+10:COEF_FRAC];
		return whole + $signed({10'b0, a[COEF_FRAC-1]});
	endfunction

endpackage

`default_nettype wire

// File: hdl/block_sequencer.sv
// Block sequencer
// Tracks the column and row of each incoming pixel of an 8x8 block and
// issues row start, row end and block end strobes for the pixel that is
// on the input now. Blocks follow each other without a gap; dropping
// enable abandons the block and restarts at pixel 0

`timescale 1ns/10ps
`default_nettype none

module block_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                enable,
	output logic                pixel_valid,
	output dct_types_pkg::idx_t col,
	output dct_types_pkg::idx_t row,
	output logic                row_start,
	output logic                row_end,
	output logic                block_end
);
	import dct_types_pkg::*;

	localparam idx_t LAST = idx_t'(BLOCK_N - 1);

	seq_state_t state;
	idx_t       col_cnt;
	idx_t       row_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= SEQ_IDLE;
			col_cnt <= '0;
			row_cnt <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					// Counters sit at zero, so this pixel is position 0
					if (enable) begin
						state   <= SEQ_STREAM;
						col_cnt <= 3'd1;
					end
				end
				SEQ_STREAM: begin
					if (!enable) begin
						state   <= SEQ_IDLE;
						col_cnt <= '0;
						row_cnt <= '0;
					end else begin
						// Row counter wraps into the next block
						col_cnt <= col_cnt + 3'd1;
						if (col_cnt == LAST)
							row_cnt <= row_cnt + 3'd1;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Strobes describe the pixel currently presented
	assign pixel_valid = enable;
	assign col         = col_cnt;
	assign row         = row_cnt;
	assign row_start   = enable && (col_cnt == '0);
	assign row_end     = enable && (col_cnt == LAST);
	assign block_end   = row_end && (row_cnt == LAST);

	// A pixel right after the block end is pixel 0 of the next block
	a_block_wrap: assert property (@(posedge clk) disable iff (rst)
		block_end |=> !enable || (row_start && (row == '0)));

endmodule

`default_nettype wire

// File: hdl/dc_row_path.sv
// DC row path
// Accumulates the u = 0 term of each image row. The level shift is applied
// once to the row total rather than to every pixel. Pipeline is product,
// accumulate, round; row_valid marks the rounded result

`timescale 1ns/10ps
`default_nettype none

module dc_row_path #(
	parameter int LEVEL_SHIFT = 128
) (
	input  logic                     clk,
	input  logic                     rst,
	input  dct_types_pkg::pixel_t    data_in,
	input  logic                     pixel_valid,
	input  logic                     row_start,
	input  logic                     row_end,
	output dct_types_pkg::row_coef_t dc_result,
	output logic                     row_valid
);
	import dct_types_pkg::*;
	import dct_coeff_pkg::*;

	// Shift times the sum of the eight DC weights
	localparam acc_t SHIFT_TOTAL = acc_t'(LEVEL_SHIFT * BLOCK_N * COEF_DC);

	acc_t prod;
	acc_t acc;
	logic prod_valid;
	logic prod_start;
	logic prod_end;
	logic acc_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_start <= 1'b0;
			prod_end   <= 1'b0;
			acc_done   <= 1'b0;
			row_valid  <= 1'b0;
		end else begin
			prod_valid <= pixel_valid;
			prod_start <= row_start;
			prod_end   <= row_end;
			acc_done   <= prod_valid && prod_end;
			row_valid  <= acc_done;
		end
	end

	always_ff @(posedge clk) begin
		if (pixel_valid)
			prod <= $signed({1'b0, data_in}) * COEF_DC;
		// Each row restarts the sum with its first product
		if (prod_valid)
			acc <= prod_start ? prod : acc + prod;
		if (acc_done)
			dc_result <= round_frac(acc - SHIFT_TOTAL);
	end

endmodule

`default_nettype wire

// File: hdl/ac_row_path.sv
// AC row path
// Seven multiply-accumulate lanes for the row terms u = 1..7. Each lane
// picks T[u][col] for the pixel on the input, sums the row and rounds it
// on the same three-stage schedule as the DC row path, so all eight row
// results are valid together

`timescale 1ns/10ps
`default_nettype none

module ac_row_path (
	input  logic                     clk,
	input  logic                     rst,
	input  dct_types_pkg::pixel_t    data_in,
	input  logic                     pixel_valid,
	input  dct_types_pkg::idx_t      col,
	input  logic                     row_start,
	input  logic                     row_end,
	output dct_types_pkg::row_coef_t ac_result [1:7]
);
	import dct_types_pkg::*;
	import dct_coeff_pkg::*;

	acc_t prod [1:7];
	acc_t acc  [1:7];
	logic prod_valid;
	logic prod_start;
	logic prod_end;
	logic acc_done;

	// Stage flags mirror the DC path
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_start <= 1'b0;
			prod_end   <= 1'b0;
			acc_done   <= 1'b0;
		end else begin
			prod_valid <= pixel_valid;
			prod_start <= row_start;
			prod_end   <= row_end;
			acc_done   <= prod_valid && prod_end;
		end
	end

	// Coefficient depends on lane and current column
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			for (int u = 1; u < BLOCK_N; u++) begin
				prod[u] <= $signed({1'b0, data_in}) * dct_coeff(idx_t'(u), col);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int u = 1; u < BLOCK_N; u++) begin
				acc[u] <= prod_start ? prod[u] : acc[u] + prod[u];
			end
		end
	end

	// No level correction here, AC weights of a row sum to zero
	always_ff @(posedge clk) begin
		if (acc_done) begin
			for (int u = 1; u < BLOCK_N; u++) begin
				ac_result[u] <= round_frac(acc[u]);
			end
		end
	end

	a_start_end_excl: assert property (@(posedge clk) disable iff (rst)
		!(row_start && row_end));

endmodule

`default_nettype wire

// File: hdl/column_transform.sv
// Column transform
// Second pass of the 2-D DCT. Each set of row results is multiplied by
// T[v][row] for all v, summed into an 8x8 accumulator that restarts on
// row 0, and rounded into the output block after the last row. The
// output_enable pulse marks a freshly written block

`timescale 1ns/10ps
`default_nettype none

module column_transform (
	input  logic                     clk,
	input  logic                     rst,
	input  dct_types_pkg::idx_t      row,
	input  logic                     row_end,
	input  logic                     block_end,
	input  logic                     row_valid,
	input  dct_types_pkg::row_coef_t dc_result,
	input  dct_types_pkg::row_coef_t ac_result [1:7],
	output dct_types_pkg::coef_t     z_out [dct_types_pkg::BLOCK_N][dct_types_pkg::BLOCK_N],
	output logic                     output_enable
);
	import dct_types_pkg::*;
	import dct_coeff_pkg::*;

	row_coef_t row_vec [BLOCK_N];
	idx_t      row_q;
	logic      last_q;
	acc_t      prod [BLOCK_N][BLOCK_N];
	acc_t      acc  [BLOCK_N][BLOCK_N];
	logic      prod_valid;
	logic      prod_first;
	logic      prod_last;
	logic      acc_last;

	// Row results gathered by frequency index u
	always_comb begin
		row_vec[0] = dc_result;
		for (int u = 1; u < BLOCK_N; u++) begin
			row_vec[u] = ac_result[u];
		end
	end

	// Row index and block end travel with the row until its results arrive
	always_ff @(posedge clk) begin
		if (rst) begin
			row_q  <= '0;
			last_q <= 1'b0;
		end else if (row_end) begin
			row_q  <= row;
			last_q <= block_end;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid    <= 1'b0;
			prod_first    <= 1'b0;
			prod_last     <= 1'b0;
			acc_last      <= 1'b0;
			output_enable <= 1'b0;
		end else begin
			prod_valid    <= row_valid;
			prod_first    <= row_valid && (row_q == '0);
			prod_last     <= row_valid && last_q;
			acc_last      <= prod_valid && prod_last;
			output_enable <= acc_last;
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid) begin
			for (int v = 0; v < BLOCK_N; v++) begin
				for (int u = 0; u < BLOCK_N; u++) begin
					prod[v][u] <= dct_coeff(idx_t'(v), row_q) * row_vec[u];
				end
			end
		end
	end

	// Row 0 overwrites, which lets the next block follow directly
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int v = 0; v < BLOCK_N; v++) begin
				for (int u = 0; u < BLOCK_N; u++) begin
					acc[v][u] <= prod_first ? prod[v][u] : acc[v][u] + prod[v][u];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int v = 0; v < BLOCK_N; v++) begin
				for (int u = 0; u < BLOCK_N; u++) begin
					z_out[v][u] <= '0;
				end
			end
		end else if (acc_last) begin
			for (int v = 0; v < BLOCK_N; v++) begin
				for (int u = 0; u < BLOCK_N; u++) begin
					z_out[v][u] <= round_frac(acc[v][u]);
				end
			end
		end
	end

	a_oe_single: assert property (@(posedge clk) disable iff (rst)
		output_enable |=> !output_enable);

endmodule

`default_nettype wire

// File: hdl/dct_2d.sv
// 2-D DCT top level
// Streaming 8x8 forward DCT for one 8-bit channel. Pixels enter row-major
// while enable is high; five cycles after the 64th pixel the signed
// coefficient block appears on z_out with a one-cycle output_enable

`timescale 1ns/10ps
`default_nettype none

module dct_2d #(
	parameter int LEVEL_SHIFT = 128
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enable,
	input  dct_types_pkg::pixel_t data_in,
	output dct_types_pkg::coef_t  z_out [dct_types_pkg::BLOCK_N][dct_types_pkg::BLOCK_N],
	output logic                  output_enable
);
	import dct_types_pkg::*;

	logic      pixel_valid;
	idx_t      col;
	idx_t      row;
	logic      row_start;
	logic      row_end;
	logic      block_end;
	row_coef_t dc_result;
	row_coef_t ac_result [1:7];
	logic      row_valid;

	block_sequencer u_seq (
		.clk         (clk),
		.rst         (rst),
		.enable      (enable),
		.pixel_valid (pixel_valid),
		.col         (col),
		.row         (row),
		.row_start   (row_start),
		.row_end     (row_end),
		.block_end   (block_end)
	);

	// First pass, DC and AC terms side by side
	dc_row_path #(
		.LEVEL_SHIFT (LEVEL_SHIFT)
	) u_dc (
		.clk         (clk),
		.rst         (rst),
		.data_in     (data_in),
		.pixel_valid (pixel_valid),
		.row_start   (row_start),
		.row_end     (row_end),
		.dc_result   (dc_result),
		.row_valid   (row_valid)
	);

	ac_row_path u_ac (
		.clk         (clk),
		.rst         (rst),
		.data_in     (data_in),
		.pixel_valid (pixel_valid),
		.col         (col),
		.row_start   (row_start),
		.row_end     (row_end),
		.ac_result   (ac_result)
	);

	column_transform u_col (
		.clk           (clk),
		.rst           (rst),
		.row           (row),
		.row_end       (row_end),
		.block_end     (block_end),
		.row_valid     (row_valid),
		.dc_result     (dc_result),
		.ac_result     (ac_result),
		.z_out         (z_out),
		.output_enable (output_enable)
	);

endmodule

`default_nettype wire

// File: sim/dct_ref_model.svh
// DCT reference model
// Computes the expected coefficient block straight from the cosine
// definition of the basis, with the level shift, both passes and the
// rounding rule. Also holds the Fibonacci LFSR step for random pixels

`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

localparam real PI = 3.14159265358979323846;

// Scaled basis value, nearest integer of the real cosine weight
function automatic longint basis_weight(input int u, input int c);
	real w;
	if (u == 0)
		w = $sqrt(0.125);
	else
		w = 0.5 * $cos((2 * c + 1) * u * PI / 16.0);
	w = w * (1 << COEF_FRAC);
	if (w >= 0.0)
		return $rtoi(w + 0.5);
	return -$rtoi(0.5 - w);
endfunction

// Floor of the integer part, plus one when the top fraction bit is set
function automatic longint round_ref(input longint a);
	longint whole;
	whole = a >>> COEF_FRAC;
	if (a[COEF_FRAC-1])
		whole = whole + 1;
	return whole;
endfunction

// Expected block for the 64 pixels of stim starting at base, into exp_z
task automatic compute_model(input int base);
	longint    p [BLOCK_N][BLOCK_N];
	longint    sum;
	longint    whole;
	row_coef_t p_bits;
	int        pv;
	for (int r = 0; r < BLOCK_N; r++) begin
		for (int u = 0; u < BLOCK_N; u++) begin
			sum = 0;
			for (int c = 0; c < BLOCK_N; c++) begin
				pv = stim[base + r * BLOCK_N + c];
				sum = sum + basis_weight(u, c) * pv;
			end
			// Level shift folded into the DC row total
			if (u == 0)
				sum = sum - LEVEL_SHIFT * BLOCK_N * basis_weight(0, 0);
			whole = round_ref(sum);
			p_bits = whole[10:0];
			p[r][u] = p_bits;
		end
	end
	for (int v = 0; v < BLOCK_N; v++) begin
		for (int u = 0; u < BLOCK_N; u++) begin
			sum = 0;
			for (int r = 0; r < BLOCK_N; r++)
				sum = sum + basis_weight(v, r) * p[r][u];
			whole = round_ref(sum);
			exp_z[v][u] = whole[10:0];
		end
	end
endtask

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: sim/dct_2d_tb.sv
// 2-D DCT testbench
// Directed tests for the streaming 8x8 DCT: reset state, uniform blocks,
// a single bright pixel, back-to-back random blocks and an aborted block

`timescale 1ns/10ps
`default_nettype none

module dct_2d_tb;
	import dct_types_pkg::*;
	import dct_coeff_pkg::*;

	localparam int LEVEL_SHIFT = 128;
	localparam int OE_LATENCY = 5;
	localparam int OE_TIMEOUT = 20;
	localparam int MAX_PIX = 3 * 64;

	logic   clk = 1'b0;
	logic   rst;
	logic   enable;
	pixel_t data_in;
	coef_t  z_out [BLOCK_N][BLOCK_N];
	logic   output_enable;

	pixel_t      stim [MAX_PIX];
	coef_t       exp_z [BLOCK_N][BLOCK_N];
	logic [31:0] lfsr_state;
	int          coef_errors;
	int          bit_errors;
	int          other_errors;

	`include "dct_ref_model.svh"

	dct_2d #(
		.LEVEL_SHIFT (LEVEL_SHIFT)
	) DUT (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.data_in       (data_in),
		.z_out         (z_out),
		.output_enable (output_enable)
	);

	always #10 clk = ~clk;

	task automatic check_coef(input string name, input coef_t expected, input coef_t actual);
		if (actual !== expected) begin
			coef_errors++;
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			bit_errors++;
			$display("FAIL %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic compare_block(input string name);
		for (int v = 0; v < BLOCK_N; v++) begin
			for (int u = 0; u < BLOCK_N; u++)
				check_coef($sformatf("%s z[%0d][%0d]", name, v, u), exp_z[v][u], z_out[v][u]);
		end
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic wait_drive_slot();
		@(posedge clk);
		#2;
	endtask

	task automatic draw_pixel(output pixel_t p);
		p = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			p = {p[6:0], lfsr_state[0]};
		end
	endtask

	// Streams n_blocks from stim without a gap and checks every pulse slot
	task automatic stream_blocks(input string name, input int n_blocks);
		int   total;
		int   step;
		int   seen;
		int   ofs;
		logic due;
		total = n_blocks * 64;
		seen = 0;
		wait_drive_slot();
		enable = 1'b1;
		data_in = stim[0];
		step = 1;
		while (seen < n_blocks && step <= total + OE_TIMEOUT) begin
			wait_drive_slot();
			// Last pixel of block b is driven at step 64b+63
			ofs = step - 64 - OE_LATENCY;
			due = (ofs >= 0) && (ofs % 64 == 0) && (ofs / 64 < n_blocks);
			check_bit($sformatf("%s output_enable at step %0d", name, step), due,
				output_enable);
			if (output_enable) begin
				compute_model(seen * 64);
				compare_block($sformatf("%s block %0d", name, seen));
				seen++;
			end
			if (step < total) begin
				enable = 1'b1;
				data_in = stim[step];
			end else begin
				enable = 1'b0;
				data_in = '0;
			end
			step++;
		end
		enable = 1'b0;
		if (seen < n_blocks) begin
			other_errors++;
			$display("Timeout in %s: only %0d of %0d output_enable pulses arrived",
				name, seen, n_blocks);
		end
	endtask

	task automatic test_reset();
		check_bit("reset output_enable", 1'b0, output_enable);
		for (int v = 0; v < BLOCK_N; v++) begin
			for (int u = 0; u < BLOCK_N; u++)
				check_coef($sformatf("reset z[%0d][%0d]", v, u), '0, z_out[v][u]);
		end
	endtask

	task automatic test_uniform(input string name, input pixel_t level);
		for (int i = 0; i < 64; i++)
			stim[i] = level;
		stream_blocks(name, 1);
	endtask

	task automatic test_bright_pixel();
		for (int i = 0; i < 64; i++)
			stim[i] = 8'd128;
		stim[2 * BLOCK_N + 5] = 8'd255;
		stream_blocks("bright_pixel", 1);
	endtask

	task automatic test_back_to_back();
		for (int i = 0; i < MAX_PIX; i++)
			draw_pixel(stim[i]);
		stream_blocks("back_to_back", 3);
	endtask

	task automatic test_abort();
		for (int i = 0; i < 30; i++)
			draw_pixel(stim[i]);
		wait_drive_slot();
		for (int i = 0; i < 30; i++) begin
			enable = 1'b1;
			data_in = stim[i];
			wait_drive_slot();
		end
		enable = 1'b0;
		data_in = '0;
		// The partial block never reaches its end, so no pulse may follow
		for (int step = 0; step < 2 * OE_TIMEOUT; step++) begin
			check_bit("abort output_enable", 1'b0, output_enable);
			wait_drive_slot();
		end
		compare_block("abort hold");
		for (int i = 0; i < 64; i++)
			draw_pixel(stim[i]);
		stream_blocks("after_abort", 1);
	endtask

	initial begin
		rst = 1'b1;
		enable = 1'b0;
		data_in = '0;
		coef_errors = 0;
		bit_errors = 0;
		other_errors = 0;
		lfsr_state = 32'h3050724d;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		test_reset();
		test_uniform("uniform_128", 8'd128);
		test_uniform("uniform_200", 8'd200);
		test_bright_pixel();
		test_back_to_back();
		test_abort();

		$display("Summary: %0d coefficient errors, %0d output_enable errors, %0d other errors",
			coef_errors, bit_errors, other_errors);
		if (coef_errors + bit_errors + other_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dct_2d.f
+incdir+sim
hdl/dct_types_pkg.sv
hdl/dct_coeff_pkg.sv
hdl/block_sequencer.sv
hdl/dc_row_path.sv
hdl/ac_row_path.sv
hdl/column_transform.sv
hdl/dct_2d.sv
sim/dct_2d_tb.sv
